// File: l2_cache.f
src/l2_pkg.sv
src/l2_req_arbiter.sv
src/l2_tag_array.sv
src/l2_data_array.sv
src/l2_plru.sv
src/l2_ctrl.sv
src/l2_cache.sv
tb/l2_clock_gen.sv
tb/l2_cache_assert.sv
tb/l2_cache_tb.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - files:
      - src/l2_pkg.sv
      - src/l2_req_arbiter.sv
      - src/l2_tag_array.sv
      - src/l2_data_array.sv
      - src/l2_plru.sv
      - src/l2_ctrl.sv
      - src/l2_cache.sv
  - target: test
    files:
      - tb/l2_clock_gen.sv
      - tb/l2_cache_assert.sv
      - tb/l2_cache_tb.sv

// File: tb/l2_cache_tb.sv
`default_nettype none

module l2_cache_tb;

    logic clk, rst;
    logic icache_req, dcache_req, dcache_write;
    l2_pkg::addr_t icache_addr, dcache_addr, mem_rd_addr;
    l2_pkg::word_t dcache_wdata;
    l2_pkg::strb_t dcache_wstrb;
    logic icache_addr_ok, icache_data_ok, dcache_addr_ok, dcache_data_ok;
    l2_pkg::line_t rdata, mem_rdata;
    logic mem_req_r, mem_req_w, mem_addr_ok_r, mem_addr_ok_w, mem_data_ok;
    l2_pkg::mem_wr_t mem_wr;

    l2_pkg::word_t mem_words [l2_pkg::addr_t];
    l2_pkg::word_t shadow [l2_pkg::addr_t];
    bit written [l2_pkg::addr_t];
    l2_pkg::line_t exp_line [$];
    l2_pkg::req_src_e exp_src [$];
    l2_pkg::addr_t cur_line;
    int cycle, issued, mem_reads, mem_writes;

    l2_clock_gen #(.period(40)) u_clk (.clk(clk));

    l2_cache #(.index_width(2)) dut (.*);

    function automatic l2_pkg::word_t init_word(l2_pkg::addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h1234abcd;
    endfunction

    function automatic l2_pkg::addr_t line_addr(int tag, int set);
        return l2_pkg::addr_t'(32'h1000 + (tag << 6) + (set << 4));
    endfunction

    function automatic l2_pkg::word_t shadow_word(l2_pkg::addr_t w);
        return shadow.exists(w) ? shadow[w] : init_word(w);
    endfunction

    function automatic l2_pkg::line_t ref_read_line(l2_pkg::addr_t a);
        l2_pkg::line_t l;
        for (int i = 0; i < l2_pkg::line_words; i++) begin
            l[i*32 +: 32] = shadow_word({a[31:4], 4'b0} + 4 * i);
        end
        return l;
    endfunction

    function automatic l2_pkg::line_t mem_line(l2_pkg::addr_t a);
        l2_pkg::line_t l;
        l2_pkg::addr_t w;
        for (int i = 0; i < l2_pkg::line_words; i++) begin
            w = a + 4 * i;
            l[i*32 +: 32] = mem_words.exists(w) ? mem_words[w] : init_word(w);
        end
        return l;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic fail(input string msg);
        stop_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    task automatic check_line(input l2_pkg::line_t got, input l2_pkg::line_t exp,
                              input string msg);
        if (got !== exp) fail($sformatf("%s: line %h, expected %h", msg, got, exp));
    endtask

    task automatic check_addr(input l2_pkg::addr_t got, input l2_pkg::addr_t exp,
                              input string msg);
        if (got !== exp) fail($sformatf("%s: address %h, expected %h", msg, got, exp));
    endtask

    task automatic check_src(input l2_pkg::req_src_e got, input l2_pkg::req_src_e exp);
        if (got !== exp) fail($sformatf("data_ok on %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp) fail($sformatf("%s: %0d, expected %0d", msg, got, exp));
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    // memory model answering one request at a time
    always @(negedge clk) begin
        if (mem_req_w) begin
            mem_writes++;
            check_addr(mem_wr.addr, {mem_wr.addr[31:6], cur_line[5:4], 4'b0},
                       "write-back address");
            check_line(mem_wr.line, ref_read_line(mem_wr.addr), "write-back content");
            for (int i = 0; i < l2_pkg::line_words; i++) begin
                mem_words[mem_wr.addr + 4 * i] = mem_wr.line[i*32 +: 32];
            end
            repeat ($urandom_range(5, 0)) @(posedge clk);
            @(posedge clk) mem_addr_ok_w <= 1'b1;
            @(posedge clk) mem_addr_ok_w <= 1'b0;
        end else if (mem_req_r) begin
            mem_reads++;
            check_addr(mem_rd_addr, cur_line, "refill address");
            repeat ($urandom_range(5, 0)) @(posedge clk);
            @(posedge clk) mem_addr_ok_r <= 1'b1;
            @(posedge clk) mem_addr_ok_r <= 1'b0;
            repeat ($urandom_range(5, 0)) @(posedge clk);
            mem_rdata <= mem_line(mem_rd_addr);
            mem_data_ok <= 1'b1;
            @(posedge clk) mem_data_ok <= 1'b0;
        end
    end

    // compares every response with the expectation queued at addr_ok
    always @(negedge clk) begin
        if (icache_data_ok || dcache_data_ok) begin
            if (exp_line.size() == 0) fail("data_ok with no request outstanding");
            check_src(dcache_data_ok ? l2_pkg::src_dcache : l2_pkg::src_icache,
                      exp_src.pop_front());
            check_line(rdata, exp_line.pop_front(), "response line");
        end
    end

    always @(negedge clk) begin
        if (dut.u_ctrl.u_assert.fail_count != 0) begin
            stop_run("a protocol assertion in l2_cache_assert failed");
        end
    end

    always @(posedge clk) begin
        if (cycle > 16 + 200 * (issued + 1)) begin
            stop_run("timeout: the cache stopped answering requests");
        end
    end

    task automatic issue(input l2_pkg::req_src_e src, input l2_pkg::addr_t a, input logic wr,
                         input l2_pkg::word_t wd, input l2_pkg::strb_t ws,
                         output int acc, output int lat);
        logic is_d;
        l2_pkg::addr_t wa;
        l2_pkg::word_t new_word;
        is_d = (src == l2_pkg::src_dcache);
        @(posedge clk);
        issued++;
        if (is_d) begin
            dcache_req <= 1'b1;
            dcache_addr <= a;
            dcache_write <= wr;
            dcache_wdata <= wd;
            dcache_wstrb <= ws;
        end else begin
            icache_req <= 1'b1;
            icache_addr <= a;
        end
        do @(negedge clk); while (!(is_d ? dcache_addr_ok : icache_addr_ok));
        acc = cycle;
        cur_line = {a[31:4], 4'b0};
        if (wr) begin
            wa = {a[31:2], 2'b0};
            new_word = shadow_word(wa);
            for (int b = 0; b < 4; b++) begin
                if (ws[b]) begin
                    new_word[b*8 +: 8] = wd[b*8 +: 8];
                end
            end
            shadow[wa] = new_word;
            written[cur_line] = 1'b1;
        end
        exp_line.push_back(ref_read_line(a));
        exp_src.push_back(src);
        @(posedge clk);
        if (is_d) dcache_req <= 1'b0;
        else icache_req <= 1'b0;
        do @(negedge clk); while (!(is_d ? dcache_data_ok : icache_data_ok));
        lat = cycle - acc;
    endtask

    task automatic rd(input l2_pkg::req_src_e src, input l2_pkg::addr_t a);
        int acc, lat;
        issue(src, a, 1'b0, '0, '0, acc, lat);
    endtask

    task automatic wr(input l2_pkg::addr_t a);
        int acc, lat;
        issue(l2_pkg::src_dcache, a, 1'b1, $urandom, l2_pkg::strb_t'($urandom), acc, lat);
    endtask

    initial begin
        int acc, lat, acc_i, lat_i, r0, w0;
        l2_pkg::addr_t a;
        void'($urandom(67705));
        {icache_req, dcache_req, dcache_write} = '0;
        {icache_addr, dcache_addr, dcache_wdata, dcache_wstrb} = '0;
        {mem_addr_ok_r, mem_addr_ok_w, mem_data_ok} = '0;
        mem_rdata = '0;
        cur_line = '0;
        {cycle, issued, mem_reads, mem_writes} = '0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // each cold miss makes one refill
        for (int s = 0; s < 4; s++) begin
            r0 = mem_reads;
            rd(s[0] ? l2_pkg::src_icache : l2_pkg::src_dcache, line_addr(0, s) + 4 * s);
            check_count(mem_reads - r0, 1, "memory reads per cold miss");
        end
        // resident lines answer in two cycles
        for (int s = 0; s < 4; s++) begin
            r0 = mem_reads + mem_writes;
            issue(l2_pkg::src_icache, line_addr(0, s), 1'b0, '0, '0, acc, lat);
            check_count(lat, 2, "hit latency");
            check_count(mem_reads + mem_writes - r0, 0, "memory requests on a hit");
        end
        for (int i = 0; i < 8; i++) begin
            a = line_addr(0, i % 4) + 4 * $urandom_range(3, 0);
            wr(a);
            rd(i[0] ? l2_pkg::src_icache : l2_pkg::src_dcache, a);
        end
        // six tags in set 1 force dirty evictions
        w0 = mem_writes;
        for (int t = 1; t <= 6; t++) wr(line_addr(t, 1) + 4 * (t % 4));
        for (int t = 0; t <= 6; t++) rd(l2_pkg::src_icache, line_addr(t, 1));
        check_count(mem_writes > w0, 1, "dirty evictions seen");
        // both ports in the same cycle
        fork
            issue(l2_pkg::src_dcache, line_addr(2, 2), 1'b0, '0, '0, acc, lat);
            issue(l2_pkg::src_icache, line_addr(3, 3), 1'b0, '0, '0, acc_i, lat_i);
        join
        check_count(acc < acc_i, 1, "dcache accepted before icache");
        for (int i = 0; i < 200; i++) begin
            a = line_addr($urandom_range(7, 0), $urandom_range(3, 0)) + 4 * $urandom_range(3, 0);
            if ($urandom_range(1, 0)) wr(a);
            else rd($urandom_range(1, 0) ? l2_pkg::src_icache : l2_pkg::src_dcache, a);
        end
        // fresh lines push every dirty line out to memory
        for (int t = 16; t < 20; t++) begin
            for (int s = 0; s < 4; s++) rd(l2_pkg::src_dcache, line_addr(t, s));
        end
        foreach (written[la]) check_line(mem_line(la), ref_read_line(la), "memory after sweep");
        if (dut.u_ctrl.u_assert.fail_count != 0) begin
            stop_run("a protocol assertion in l2_cache_assert failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/l2_cache_assert.sv
`default_nettype none

module l2_cache_assert (
    input logic                clk,
    input logic                rst,
    input l2_pkg::ctrl_state_e state,
    input logic                accept,
    input logic                mem_req_r,
    input logic                mem_req_w,
    input logic                icache_data_ok,
    input logic                dcache_data_ok
);

    logic outstanding;
    logic data_ok;
    int fail_count = 0;

    assign data_ok = icache_data_ok | dcache_data_ok;

    // set by addr_ok and cleared by data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (accept) begin
            outstanding <= 1'b1;
        end else if (data_ok) begin
            outstanding <= 1'b0;
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_req_r && mem_req_w))
        else begin
            $error("mem_req_r and mem_req_w high together");
            fail_count++;
        end
    a_data_ok_owed: assert property (@(posedge clk) disable iff (rst) data_ok |-> outstanding)
        else begin
            $error("data_ok without an outstanding addr_ok");
            fail_count++;
        end
    a_one_at_a_time: assert property (@(posedge clk) disable iff (rst)
        accept |-> !outstanding && state == l2_pkg::st_idle)
        else begin
            $error("addr_ok given before the previous data_ok");
            fail_count++;
        end
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !(accept || mem_req_r || mem_req_w || data_ok))
        else begin
            $error("handshake output high after reset");
            fail_count++;
        end

endmodule

bind l2_ctrl l2_cache_assert u_assert (
    .clk(clk), .rst(rst), .state(state), .accept(accept),
    .mem_req_r(mem_req_r), .mem_req_w(mem_req_w),
    .icache_data_ok(icache_data_ok), .dcache_data_ok(dcache_data_ok)
);

`default_nettype wire

// File: tb/l2_clock_gen.sv
`default_nettype none

module l2_clock_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: src/l2_cache.sv
`default_nettype none

module l2_cache #(
    parameter int index_width = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             icache_req,
    input  l2_pkg::addr_t    icache_addr,
    input  logic             dcache_req,
    input  logic             dcache_write,
    input  l2_pkg::addr_t    dcache_addr,
    input  l2_pkg::word_t    dcache_wdata,
    input  l2_pkg::strb_t    dcache_wstrb,
    output logic             icache_addr_ok,
    output logic             icache_data_ok,
    output logic             dcache_addr_ok,
    output logic             dcache_data_ok,
    output l2_pkg::line_t    rdata,
    output logic             mem_req_r,
    output l2_pkg::addr_t    mem_rd_addr,
    output logic             mem_req_w,
    output l2_pkg::mem_wr_t  mem_wr,
    input  logic             mem_addr_ok_r,
    input  logic             mem_addr_ok_w,
    input  logic             mem_data_ok,
    input  l2_pkg::line_t    mem_rdata
);

    localparam int offset_width = $clog2(l2_pkg::line_words) + 2;
    localparam int tag_width = $bits(l2_pkg::addr_t) - index_width - offset_width;

    l2_pkg::l1_req_t req;
    l2_pkg::line_t line;
    l2_pkg::way_t hit_way;
    l2_pkg::way_t victim_way;
    l2_pkg::way_t sel_way;
    logic [l2_pkg::num_ways-1:0] valid_mask;
    logic [tag_width-1:0] victim_tag;
    logic pending, accept, hit, victim_dirty;
    logic tag_we, set_dirty, clear_dirty, data_refill, data_word_we, plru_touch;

    l2_req_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .dcache_req(dcache_req), .dcache_write(dcache_write), .dcache_addr(dcache_addr),
        .dcache_wdata(dcache_wdata), .dcache_wstrb(dcache_wstrb),
        .accept(accept), .icache_addr_ok(icache_addr_ok), .dcache_addr_ok(dcache_addr_ok),
        .pending(pending), .req(req)
    );

    l2_tag_array #(.index_width(index_width)) u_tags (
        .clk(clk), .rst(rst), .req(req), .tag_we(tag_we), .set_dirty(set_dirty),
        .clear_dirty(clear_dirty), .sel_way(sel_way), .hit(hit), .hit_way(hit_way),
        .valid_mask(valid_mask), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    l2_data_array #(.index_width(index_width)) u_data (
        .clk(clk), .req(req), .sel_way(sel_way), .data_refill(data_refill),
        .data_word_we(data_word_we), .refill_line(mem_rdata), .line(line)
    );

    l2_plru #(.index_width(index_width)) u_plru (
        .clk(clk), .rst(rst), .req(req), .valid_mask(valid_mask),
        .plru_touch(plru_touch), .sel_way(sel_way), .victim_way(victim_way)
    );

    l2_ctrl u_ctrl (
        .clk(clk), .rst(rst), .pending(pending), .req(req), .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty),
        .mem_addr_ok_r(mem_addr_ok_r), .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok(mem_data_ok), .accept(accept), .sel_way(sel_way), .tag_we(tag_we),
        .set_dirty(set_dirty), .clear_dirty(clear_dirty), .data_refill(data_refill),
        .data_word_we(data_word_we), .plru_touch(plru_touch),
        .mem_req_r(mem_req_r), .mem_req_w(mem_req_w),
        .icache_data_ok(icache_data_ok), .dcache_data_ok(dcache_data_ok)
    );

    assign rdata = line;

    // line-aligned refill and write-back addresses
    assign mem_rd_addr = {req.addr[$bits(l2_pkg::addr_t)-1:offset_width], {offset_width{1'b0}}};
    assign mem_wr.addr = {victim_tag, req.addr[offset_width +: index_width],
                          {offset_width{1'b0}}};
    assign mem_wr.line = line;

endmodule

`default_nettype wire

// File: src/l2_ctrl.sv
`default_nettype none

module l2_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             pending,
    input  l2_pkg::l1_req_t  req,
    input  logic             hit,
    input  l2_pkg::way_t     hit_way,
    input  l2_pkg::way_t     victim_way,
    input  logic             victim_dirty,
    input  logic             mem_addr_ok_r,
    input  logic             mem_addr_ok_w,
    input  logic             mem_data_ok,
    output logic             accept,
    output l2_pkg::way_t     sel_way,
    output logic             tag_we,
    output logic             set_dirty,
    output logic             clear_dirty,
    output logic             data_refill,
    output logic             data_word_we,
    output logic             plru_touch,
    output logic             mem_req_r,
    output logic             mem_req_w,
    output logic             icache_data_ok,
    output logic             dcache_data_ok
);

    l2_pkg::ctrl_state_e state;
    l2_pkg::ctrl_state_e state_next;
    l2_pkg::way_t way_q;

    logic in_lookup;
    logic write_hit;
    logic refill_fill;
    logic data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l2_pkg::st_idle;
            way_q <= '0;
        end else begin
            state <= state_next;
            // way chosen at lookup is kept for the rest of the miss
            if (in_lookup) begin
                way_q <= sel_way;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            l2_pkg::st_idle: begin
                if (pending) begin
                    state_next = l2_pkg::st_lookup;
                end
            end
            l2_pkg::st_lookup: begin
                if (hit) begin
                    state_next = l2_pkg::st_respond;
                end else if (victim_dirty) begin
                    state_next = l2_pkg::st_wb;
                end else begin
                    state_next = l2_pkg::st_refill_req;
                end
            end
            l2_pkg::st_respond: state_next = l2_pkg::st_idle;
            l2_pkg::st_wb: begin
                if (mem_addr_ok_w) begin
                    state_next = l2_pkg::st_refill_req;
                end
            end
            l2_pkg::st_refill_req: begin
                if (mem_addr_ok_r) begin
                    state_next = l2_pkg::st_refill_wait;
                end
            end
            l2_pkg::st_refill_wait: begin
                if (mem_data_ok) begin
                    state_next = l2_pkg::st_respond;
                end
            end
            default: state_next = l2_pkg::st_idle;
        endcase
    end

    assign in_lookup = (state == l2_pkg::st_lookup);
    assign write_hit = in_lookup & hit & req.write;
    assign refill_fill = (state == l2_pkg::st_refill_wait) & mem_data_ok;
    assign data_ok = (state == l2_pkg::st_respond);

    assign accept = (state == l2_pkg::st_idle) & pending;

    // victim on a miss, hit way otherwise
    assign sel_way = in_lookup ? (hit ? hit_way : victim_way) : way_q;

    assign tag_we = refill_fill;
    assign data_refill = refill_fill;
    assign data_word_we = write_hit;
    assign set_dirty = write_hit | (refill_fill & req.write);
    assign clear_dirty = refill_fill & ~req.write;
    assign plru_touch = (in_lookup & hit) | refill_fill;

    assign mem_req_w = (state == l2_pkg::st_wb);
    assign mem_req_r = (state == l2_pkg::st_refill_req);

    assign icache_data_ok = data_ok & (req.src == l2_pkg::src_icache);
    assign dcache_data_ok = data_ok & (req.src == l2_pkg::src_dcache);

endmodule

`default_nettype wire

// File: src/l2_plru.sv
`default_nettype none

module l2_plru #(
    parameter int index_width = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  l2_pkg::l1_req_t             req,
    input  logic [l2_pkg::num_ways-1:0] valid_mask,
    input  logic                        plru_touch,
    input  l2_pkg::way_t                sel_way,
    output l2_pkg::way_t                victim_way
);

    localparam int offset_width = $clog2(l2_pkg::line_words) + 2;
    localparam int num_sets = 1 << index_width;

    // bit 0 is the root, bit 1 picks in ways 0/1, bit 2 in ways 2/3
    logic [l2_pkg::num_ways-2:0] tree [num_sets];

    logic [index_width-1:0] index;
    logic [l2_pkg::num_ways-2:0] bits;
    l2_pkg::way_t tree_way;

    assign index = req.addr[offset_width +: index_width];
    assign bits = tree[index];
    assign tree_way = bits[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};

    // lowest invalid way first
    always_comb begin
        victim_way = tree_way;
        for (int w = l2_pkg::num_ways - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim_way = l2_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (plru_touch) begin
            tree[index][0] <= ~sel_way[1];
            if (sel_way[1]) begin
                tree[index][2] <= ~sel_way[0];
            end else begin
                tree[index][1] <= ~sel_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/l2_data_array.sv
`default_nettype none

module l2_data_array #(
    parameter int index_width = 2
) (
    input  logic             clk,
    input  l2_pkg::l1_req_t  req,
    input  l2_pkg::way_t     sel_way,
    input  logic             data_refill,
    input  logic             data_word_we,
    input  l2_pkg::line_t    refill_line,
    output l2_pkg::line_t    line
);

    localparam int word_sel_width = $clog2(l2_pkg::line_words);
    localparam int offset_width = word_sel_width + 2;
    localparam int num_sets = 1 << index_width;
    localparam int word_bits = $bits(l2_pkg::word_t);
    localparam int strb_bits = $bits(l2_pkg::strb_t);

    l2_pkg::line_t lines [num_sets][l2_pkg::num_ways];

    logic [index_width-1:0] index;

    assign index = req.addr[offset_width +: index_width];

    // put the buffered word into a line under its byte strobes
    function automatic l2_pkg::line_t merge_word(l2_pkg::line_t base, l2_pkg::l1_req_t r);
        l2_pkg::line_t merged;
        logic [word_sel_width-1:0] wsel;
        merged = base;
        wsel = r.addr[2 +: word_sel_width];
        for (int b = 0; b < strb_bits; b++) begin
            if (r.wstrb[b]) begin
                merged[int'(wsel)*word_bits + b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign line = lines[index][sel_way];

    always_ff @(posedge clk) begin
        if (data_refill) begin
            // write miss merges in the same cycle as the refill
            lines[index][sel_way] <= req.write ? merge_word(refill_line, req) : refill_line;
        end else if (data_word_we) begin
            lines[index][sel_way] <= merge_word(lines[index][sel_way], req);
        end
    end

endmodule

`default_nettype wire

// File: src/l2_tag_array.sv
`default_nettype none

module l2_tag_array #(
    parameter int index_width = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  l2_pkg::l1_req_t          req,
    input  logic                     tag_we,
    input  logic                     set_dirty,
    input  logic                     clear_dirty,
    input  l2_pkg::way_t             sel_way,
    output logic                     hit,
    output l2_pkg::way_t             hit_way,
    output logic [l2_pkg::num_ways-1:0] valid_mask,
    output logic                     victim_dirty,
    output logic [$bits(l2_pkg::addr_t)-index_width-$clog2(l2_pkg::line_words)-3:0] victim_tag
);

    localparam int addr_width = $bits(l2_pkg::addr_t);
    localparam int offset_width = $clog2(l2_pkg::line_words) + 2;
    localparam int tag_width = addr_width - index_width - offset_width;
    localparam int num_sets = 1 << index_width;

    logic [tag_width-1:0] tags [num_sets][l2_pkg::num_ways];
    logic [l2_pkg::num_ways-1:0] valid [num_sets];
    logic [l2_pkg::num_ways-1:0] dirty [num_sets];

    logic [index_width-1:0] index;
    logic [tag_width-1:0] tag;

    assign index = req.addr[offset_width +: index_width];
    assign tag = req.addr[addr_width-1 -: tag_width];

    // all ways compared in parallel
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < l2_pkg::num_ways; w++) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                hit = 1'b1;
                hit_way = l2_pkg::way_t'(w);
            end
        end
    end

    assign valid_mask = valid[index];
    assign victim_dirty = dirty[index][sel_way];
    assign victim_tag = tags[index][sel_way];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[index][sel_way] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (tag_we) begin
                valid[index][sel_way] <= 1'b1;
            end
            if (set_dirty) begin
                dirty[index][sel_way] <= 1'b1;
            end else if (clear_dirty) begin
                dirty[index][sel_way] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/l2_req_arbiter.sv
`default_nettype none

module l2_req_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              icache_req,
    input  l2_pkg::addr_t     icache_addr,
    input  logic              dcache_req,
    input  logic              dcache_write,
    input  l2_pkg::addr_t     dcache_addr,
    input  l2_pkg::word_t     dcache_wdata,
    input  l2_pkg::strb_t     dcache_wstrb,
    input  logic              accept,
    output logic              icache_addr_ok,
    output logic              dcache_addr_ok,
    output logic              pending,
    output l2_pkg::l1_req_t   req
);

    l2_pkg::l1_req_t winner;

    // dcache has priority
    always_comb begin
        winner.addr  = dcache_req ? dcache_addr : icache_addr;
        winner.wdata = dcache_wdata;
        winner.wstrb = dcache_wstrb;
        winner.write = dcache_req & dcache_write;
        winner.src   = dcache_req ? l2_pkg::src_dcache : l2_pkg::src_icache;
    end

    assign pending = icache_req | dcache_req;

    assign dcache_addr_ok = accept & dcache_req;
    assign icache_addr_ok = accept & ~dcache_req & icache_req;

    // request buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            req <= '0;
        end else if (accept) begin
            req <= winner;
        end
    end

endmodule

`default_nettype wire

// File: src/l2_pkg.sv
`default_nettype none

package l2_pkg;

    localparam int line_words = 4;
    localparam int num_ways = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;
    typedef logic [line_words*32-1:0] line_t;
    typedef logic [1:0] way_t;

    typedef enum logic {
        src_icache,
        src_dcache
    } req_src_e;

    // request as held in the request buffer
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic write;
        req_src_e src;
    } l1_req_t;

    typedef struct packed {
        addr_t addr;
        line_t line;
    } mem_wr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_wb,
        st_refill_req,
        st_refill_wait
    } ctrl_state_e;

endpackage

`default_nettype wire
